// File: rtl/eic_channel.sv
`timescale 1ns/1ps
`default_nettype none

module eic_channel (
    input  wire  CLK,
    input  wire  RESETn,
    input  wire  mask,
    input  wire  signal_in,
    input  wire  request_wr,
    input  wire  request_in,
    output logic request_out
);

    always_ff @(posedge CLK) begin
        if (!RESETn) begin
            request_out <= 1'b0;
        end else if (signal_in && mask) begin
            // a live event beats any clear in the same cycle
            request_out <= 1'b1;
        end else if (request_wr) begin
            request_out <= request_in;
        end
    end

endmodule

`default_nettype wire

// File: rtl/eic_core.sv
`timescale 1ns/1ps
`default_nettype none

module eic_core (
    input  wire                        CLK,
    input  wire                        RESETn,
    input  wire eic_pkg::eic_lines_t   signal,
    input  wire eic_pkg::eic_bus_t     bus,
    input  wire eic_pkg::eic_addr_t    read_addr,
    input  wire eic_pkg::eic_cpu_ack_t ack,
    output eic_pkg::eic_word_t         read_data,
    output eic_pkg::eic_cpu_req_t      req
);

    logic                  ee_q;
    eic_pkg::eic_word_t    eimsk_q;
    eic_pkg::eic_word_t    eismsk_q;
    eic_pkg::eic_word_t    eiacm_q;
    eic_pkg::eic_word_t    eicr_word;
    eic_pkg::eic_word_t    eicr_next;
    eic_pkg::eic_word_t    eimsk_next;
    eic_pkg::eic_word_t    eismsk_next;
    eic_pkg::eic_word_t    eiacm_next;
    eic_pkg::eic_update_e  eicr_op;
    eic_pkg::eic_update_e  eimsk_op;
    eic_pkg::eic_update_e  eismsk_op;
    eic_pkg::eic_update_e  eiacm_op;
    eic_pkg::eic_update_e  flag_op;
    eic_pkg::eic_lines_t   flag_wr;
    eic_pkg::eic_lines_t   flag_data;
    eic_pkg::eic_lines_t   ack_clear;
    eic_pkg::eic_lines_t   request_wr;
    eic_pkg::eic_lines_t   request_in;
    eic_pkg::eic_lines_t   enabled;
    eic_pkg::eic_lines_t   sensed;
    eic_pkg::eic_lines_t   flags;
    logic                  detect;
    eic_pkg::eic_irq_num_t number;
    eic_pkg::eic_cpu_req_t vec_req;

    assign eicr_word = eic_pkg::eic_word_t'(ee_q) << eic_pkg::EICR_EE;

    // write address to per-register operation
    always_comb begin
        eicr_op   = eic_pkg::UPD_KEEP;
        eimsk_op  = eic_pkg::UPD_KEEP;
        eismsk_op = eic_pkg::UPD_KEEP;
        eiacm_op  = eic_pkg::UPD_KEEP;
        flag_op   = eic_pkg::UPD_KEEP;
        if (bus.write_enable) begin
            case (bus.write_addr)
                eic_pkg::REG_EICR:   eicr_op   = eic_pkg::UPD_WRITE;
                eic_pkg::REG_EIMSK:  eimsk_op  = eic_pkg::UPD_WRITE;
                eic_pkg::REG_EIFR:   flag_op   = eic_pkg::UPD_WRITE;
                eic_pkg::REG_EIFRS:  flag_op   = eic_pkg::UPD_SET;
                eic_pkg::REG_EIFRC:  flag_op   = eic_pkg::UPD_CLEAR;
                eic_pkg::REG_EISMSK: eismsk_op = eic_pkg::UPD_WRITE;
                eic_pkg::REG_EIACM:  eiacm_op  = eic_pkg::UPD_WRITE;
                default: ;
            endcase
        end
    end

    eic_reg_update u_upd_eicr (.cur(eicr_word), .word(bus.write_data), .op(eicr_op),
                               .next(eicr_next));
    eic_reg_update u_upd_eimsk (.cur(eimsk_q), .word(bus.write_data), .op(eimsk_op),
                                .next(eimsk_next));
    eic_reg_update u_upd_eismsk (.cur(eismsk_q), .word(bus.write_data), .op(eismsk_op),
                                 .next(eismsk_next));
    eic_reg_update u_upd_eiacm (.cur(eiacm_q), .word(bus.write_data), .op(eiacm_op),
                                .next(eiacm_next));

    always_ff @(posedge CLK) begin
        if (!RESETn) begin
            ee_q     <= 1'b0;
            eimsk_q  <= '0;
            eismsk_q <= '0;
            eiacm_q  <= '0;
        end else begin
            ee_q     <= eicr_next[eic_pkg::EICR_EE];
            eimsk_q  <= eimsk_next;
            eismsk_q <= eismsk_next & eic_pkg::EISMSK_MASK;
            eiacm_q  <= eiacm_next;
        end
    end

    // flag writes as per-line enable and data
    always_comb begin
        case (flag_op)
            eic_pkg::UPD_WRITE: begin
                flag_wr   = '1;
                flag_data = bus.write_data;
            end
            eic_pkg::UPD_SET: begin
                flag_wr   = bus.write_data;
                flag_data = '1;
            end
            eic_pkg::UPD_CLEAR: begin
                flag_wr   = bus.write_data;
                flag_data = '0;
            end
            default: begin
                flag_wr   = '0;
                flag_data = '0;
            end
        endcase
    end

    // ivn beyond the line count shifts out to nothing
    assign ack_clear  = ack.iack ? (eiacm_q & (eic_pkg::eic_lines_t'(1) << ack.ivn)) : '0;
    assign request_wr = flag_wr | ack_clear;
    assign request_in = flag_data & ~ack_clear;
    assign enabled    = ee_q ? eimsk_q : '0;

    for (genvar i = 0; i < eic_pkg::EIC_CHANNELS; i++) begin : g_line
        if (i < eic_pkg::EIC_SENSE_CHANNELS) begin : g_sense
            eic_sense u_sense (
                .CLK        (CLK),
                .RESETn     (RESETn),
                .mode       (eic_pkg::eic_sense_e'(eismsk_q[2*i +: 2])),
                .signal_in  (signal[i]),
                .signal_out (sensed[i])
            );
        end else begin : g_level
            assign sensed[i] = signal[i];
        end

        eic_channel u_channel (
            .CLK         (CLK),
            .RESETn      (RESETn),
            .mask        (enabled[i]),
            .signal_in   (sensed[i]),
            .request_wr  (request_wr[i]),
            .request_in  (request_in[i]),
            .request_out (flags[i])
        );
    end

    eic_priority_enc u_prio (.flags(flags), .detect(detect), .number(number));

    eic_vector_enc u_vec (.number(number), .detect(detect), .req(vec_req));

    always_comb begin
        req         = vec_req;
        req.present = ee_q;
    end

    always_comb begin
        case (read_addr)
            eic_pkg::REG_EICR:   read_data = eicr_word;
            eic_pkg::REG_EIMSK:  read_data = eimsk_q;
            eic_pkg::REG_EIFR:   read_data = flags;
            eic_pkg::REG_EISMSK: read_data = eismsk_q;
            eic_pkg::REG_EIIPR:  read_data = signal;
            eic_pkg::REG_EIACM:  read_data = eiacm_q;
            // set and clear ports are write only
            default:             read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/eic_pkg.sv
`default_nettype none

package eic_pkg;

    localparam int EIC_CHANNELS       = 32;
    localparam int EIC_SENSE_CHANNELS = 8;
    localparam int EIC_ADDR_WIDTH     = 3;

    typedef logic [31:0]                 eic_word_t;
    typedef logic [EIC_ADDR_WIDTH-1:0]   eic_addr_t;
    typedef logic [EIC_CHANNELS-1:0]     eic_lines_t;
    typedef logic [5:0]                  eic_irq_num_t;
    typedef logic [7:0]                  eic_ipl_t;
    typedef logic [5:0]                  eic_vector_t;
    typedef logic [17:1]                 eic_offset_t;
    typedef logic [3:0]                  eic_shadow_t;

    // register map, one word each
    localparam eic_addr_t REG_EICR   = 3'd0;
    localparam eic_addr_t REG_EIMSK  = 3'd1;
    localparam eic_addr_t REG_EIFR   = 3'd2;
    localparam eic_addr_t REG_EIFRS  = 3'd3;
    localparam eic_addr_t REG_EIFRC  = 3'd4;
    localparam eic_addr_t REG_EISMSK = 3'd5;
    localparam eic_addr_t REG_EIIPR  = 3'd6;
    localparam eic_addr_t REG_EIACM  = 3'd7;

    localparam int EICR_EE = 0;

    // two mode bits per sensed line
    localparam eic_word_t EISMSK_MASK = eic_word_t'((64'd1 << (2 * EIC_SENSE_CHANNELS)) - 1);

    // byte addresses, offset output is in halfwords
    localparam int EIC_VECTOR_BASE    = 'h200;
    localparam int EIC_VECTOR_SPACING = 'h20;

    typedef enum logic [1:0] {
        SENSE_LEVEL = 2'd0,
        SENSE_ANY   = 2'd1,
        SENSE_FALL  = 2'd2,
        SENSE_RISE  = 2'd3
    } eic_sense_e;

    typedef enum logic [1:0] {
        UPD_KEEP  = 2'd0,
        UPD_WRITE = 2'd1,
        UPD_SET   = 2'd2,
        UPD_CLEAR = 2'd3
    } eic_update_e;

    typedef struct packed {
        logic      write_enable;
        eic_addr_t write_addr;
        eic_word_t write_data;
    } eic_bus_t;

    typedef struct packed {
        eic_offset_t offset;
        eic_shadow_t shadow_set;
        eic_ipl_t    level;
        eic_vector_t vector;
        logic        present;
    } eic_cpu_req_t;

    typedef struct packed {
        logic        iack;
        eic_ipl_t    ipl;
        eic_vector_t ivn;
    } eic_cpu_ack_t;

endpackage

`default_nettype wire

// File: rtl/eic_priority_enc.sv
`timescale 1ns/1ps
`default_nettype none

module eic_priority_enc (
    input  wire eic_pkg::eic_lines_t flags,
    output logic                     detect,
    output eic_pkg::eic_irq_num_t    number
);

    // later indices overwrite, so the highest set bit wins
    always_comb begin
        number = '0;
        for (int i = 0; i < eic_pkg::EIC_CHANNELS; i++) begin
            if (flags[i]) begin
                number = eic_pkg::eic_irq_num_t'(i);
            end
        end
    end

    assign detect = |flags;

endmodule

`default_nettype wire

// File: rtl/eic_reg_update.sv
`timescale 1ns/1ps
`default_nettype none

module eic_reg_update (
    input  wire eic_pkg::eic_word_t   cur,
    input  wire eic_pkg::eic_word_t   word,
    input  wire eic_pkg::eic_update_e op,
    output eic_pkg::eic_word_t        next
);

    always_comb begin
        case (op)
            eic_pkg::UPD_WRITE: begin
                next = word;
            end
            eic_pkg::UPD_SET: begin
                next = cur | word;
            end
            eic_pkg::UPD_CLEAR: begin
                next = cur & ~word;
            end
            default: begin
                next = cur;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/eic_sense.sv
`timescale 1ns/1ps
`default_nettype none

module eic_sense (
    input  wire                      CLK,
    input  wire                      RESETn,
    input  wire eic_pkg::eic_sense_e mode,
    input  wire                      signal_in,
    output logic                     signal_out
);

    logic prev_q;

    always_ff @(posedge CLK) begin
        if (!RESETn) begin
            prev_q <= 1'b0;
        end else begin
            prev_q <= signal_in;
        end
    end

    // edge modes give a single cycle pulse
    always_comb begin
        case (mode)
            eic_pkg::SENSE_ANY:  signal_out = signal_in ^ prev_q;
            eic_pkg::SENSE_FALL: signal_out = prev_q & ~signal_in;
            eic_pkg::SENSE_RISE: signal_out = signal_in & ~prev_q;
            default:             signal_out = signal_in;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/eic_sync.sv
`timescale 1ns/1ps
`default_nettype none

module eic_sync (
    input  wire                      CLK,
    input  wire                      RESETn,
    input  wire eic_pkg::eic_lines_t async_in,
    output eic_pkg::eic_lines_t      sync_out
);

    eic_pkg::eic_lines_t meta_q;

    always_ff @(posedge CLK) begin
        if (!RESETn) begin
            meta_q   <= '0;
            sync_out <= '0;
        end else begin
            meta_q   <= async_in;
            sync_out <= meta_q;
        end
    end

endmodule

`default_nettype wire

// File: rtl/eic_top.sv
`timescale 1ns/1ps
`default_nettype none

module eic_top (
    input  wire                        CLK,
    input  wire                        RESETn,
    input  wire eic_pkg::eic_lines_t   signal,
    input  wire eic_pkg::eic_bus_t     bus,
    input  wire eic_pkg::eic_addr_t    read_addr,
    input  wire eic_pkg::eic_cpu_ack_t ack,
    output eic_pkg::eic_word_t         read_data,
    output eic_pkg::eic_cpu_req_t      req
);

    eic_pkg::eic_lines_t signal_sync;

    // raw lines are asynchronous to CLK
    eic_sync u_sync (
        .CLK      (CLK),
        .RESETn   (RESETn),
        .async_in (signal),
        .sync_out (signal_sync)
    );

    eic_core u_core (
        .CLK       (CLK),
        .RESETn    (RESETn),
        .signal    (signal_sync),
        .bus       (bus),
        .read_addr (read_addr),
        .ack       (ack),
        .read_data (read_data),
        .req       (req)
    );

endmodule

`default_nettype wire

// File: rtl/eic_vector_enc.sv
`timescale 1ns/1ps
`default_nettype none

module eic_vector_enc (
    input  wire eic_pkg::eic_irq_num_t number,
    input  wire                        detect,
    output eic_pkg::eic_cpu_req_t      req
);

    logic [17:0] byte_offset;

    assign byte_offset = 18'(eic_pkg::EIC_VECTOR_BASE)
                       + 18'(number) * 18'(eic_pkg::EIC_VECTOR_SPACING);

    always_comb begin
        req = '0;
        if (detect) begin
            // level 0 means no request, so shift up by one
            req.level  = eic_pkg::eic_ipl_t'(number) + 8'd1;
            req.vector = number;
            req.offset = byte_offset[17:1];
        end
        req.shadow_set = '0;
        // present comes from the control register in the core
        req.present = 1'b0;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module eic_tb -f sim.f -o eic_sim || exit 1
out=$(./obj_dir/eic_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// File: sim.f
rtl/eic_pkg.sv
rtl/eic_reg_update.sv
rtl/eic_sense.sv
rtl/eic_channel.sv
rtl/eic_priority_enc.sv
rtl/eic_vector_enc.sv
rtl/eic_sync.sv
rtl/eic_core.sv
rtl/eic_top.sv
verif/eic_clkgen.sv
verif/eic_chk.sv
verif/eic_tb.sv

// File: verif/eic_chk.sv
`timescale 1ns/1ps
`default_nettype none

module eic_chk (
    input wire                        CLK,
    input wire                        RESETn,
    input wire eic_pkg::eic_cpu_req_t req,
    input wire eic_pkg::eic_lines_t   flags
);

    // registers settle one edge after reset is seen
    reset_idle: assert property (@(posedge CLK)
        !RESETn |=> (!req.present && req.level == '0))
        else $error("present or level nonzero right after reset");

    level_has_source: assert property (@(posedge CLK) disable iff (!RESETn)
        (req.level != '0) |-> (req.present || (|flags)))
        else $error("level raised with no flag and no present");

    // vector and level come from the same winning number
    vector_tracks_level: assert property (@(posedge CLK) disable iff (!RESETn)
        (req.level != '0) |-> (eic_pkg::eic_ipl_t'(req.vector) == req.level - 8'd1))
        else $error("vector does not match level minus one");

endmodule

bind eic_top eic_chk u_chk (
    .CLK    (CLK),
    .RESETn (RESETn),
    .req    (req),
    .flags  (u_core.flags)
);

`default_nettype wire

// File: verif/eic_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module eic_clkgen (
    output logic CLK,
    output logic RESETn
);

    // 20 ns period
    initial begin
        CLK = 1'b0;
        forever begin
            #10 CLK = ~CLK;
        end
    end

    // reset held for four rising edges, released on a falling edge
    initial begin
        RESETn = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESETn = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/eic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eic_tb;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_WAIT_READ, OP_LINES, OP_ACK, OP_WAIT_LEVEL, OP_PRESENT
    } op_e;

    typedef struct packed {
        op_e                op;
        eic_pkg::eic_addr_t addr;
        eic_pkg::eic_word_t data;
        eic_pkg::eic_word_t exp;
        logic               rnd;
    } step_t;

    localparam int NUM_STEPS  = 52;
    localparam int WAIT_LIMIT = 20;

    // rnd: write a random word, or expect the last random word
    localparam step_t STEPS [NUM_STEPS] = '{
        '{OP_READ,       eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIMSK,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EISMSK, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIIPR,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIACM,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_PRESENT,    eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WAIT_LEVEL, eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        // register access
        '{OP_WRITE,      eic_pkg::REG_EIMSK,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{OP_READ,       eic_pkg::REG_EIMSK,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{OP_WRITE,      eic_pkg::REG_EIACM,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{OP_READ,       eic_pkg::REG_EIACM,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{OP_WRITE,      eic_pkg::REG_EISMSK, 32'h0000_00c0, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EISMSK, 32'h0000_0000, 32'h0000_00c0, 1'b0},
        '{OP_WRITE,      eic_pkg::REG_EICR,   32'h0000_0001, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0001, 1'b0},
        '{OP_PRESENT,    eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0001, 1'b0},
        '{OP_WRITE,      eic_pkg::REG_EIFRS,  32'h0000_0100, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFRS,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFR,   32'h0000_0000, 32'h0000_0100, 1'b0},
        '{OP_WRITE,      eic_pkg::REG_EIFRC,  32'h0000_0100, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFRC,  32'h0000_0000, 32'h0000_0000, 1'b0},
        // line 20 high level
        '{OP_WRITE,      eic_pkg::REG_EIMSK,  32'h0010_0008, 32'h0000_0000, 1'b0},
        '{OP_LINES,      eic_pkg::REG_EICR,   32'h0010_0000, 32'h0000_0000, 1'b0},
        '{OP_WAIT_READ,  eic_pkg::REG_EIIPR,  32'h0000_0000, 32'h0010_0000, 1'b0},
        '{OP_WAIT_LEVEL, eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0015, 1'b0},
        '{OP_LINES,      eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WAIT_READ,  eic_pkg::REG_EIIPR,  32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WRITE,      eic_pkg::REG_EIFRC,  32'h0010_0000, 32'h0000_0000, 1'b0},
        // line 3 rising edge
        '{OP_LINES,      eic_pkg::REG_EICR,   32'h0000_0008, 32'h0000_0000, 1'b0},
        '{OP_WAIT_LEVEL, eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0004, 1'b0},
        '{OP_WRITE,      eic_pkg::REG_EIFRC,  32'h0000_0008, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_LINES,      eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WAIT_READ,  eic_pkg::REG_EIIPR,  32'h0000_0000, 32'h0000_0000, 1'b0},
        // line 3 falling edge
        '{OP_WRITE,      eic_pkg::REG_EISMSK, 32'h0000_0080, 32'h0000_0000, 1'b0},
        '{OP_LINES,      eic_pkg::REG_EICR,   32'h0000_0008, 32'h0000_0000, 1'b0},
        '{OP_WAIT_READ,  eic_pkg::REG_EIIPR,  32'h0000_0000, 32'h0000_0008, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_LINES,      eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_WAIT_LEVEL, eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0004, 1'b0},
        // priority, then global enable off
        '{OP_WRITE,      eic_pkg::REG_EIMSK,  32'h0000_0000, 32'h0000_0000, 1'b1},
        '{OP_WRITE,      eic_pkg::REG_EIFR,   32'h0002_0020, 32'h0000_0000, 1'b0},
        '{OP_WAIT_LEVEL, eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0012, 1'b0},
        '{OP_WRITE,      eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_PRESENT,    eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFR,   32'h0000_0000, 32'h0002_0020, 1'b0},
        // acknowledge with and without auto-clear
        '{OP_WRITE,      eic_pkg::REG_EIACM,  32'h0002_0000, 32'h0000_0000, 1'b0},
        '{OP_ACK,        eic_pkg::REG_EICR,   32'h0000_0011, 32'h0000_0000, 1'b0},
        '{OP_WAIT_LEVEL, eic_pkg::REG_EICR,   32'h0000_0000, 32'h0000_0006, 1'b0},
        '{OP_ACK,        eic_pkg::REG_EICR,   32'h0000_0005, 32'h0000_0000, 1'b0},
        '{OP_READ,       eic_pkg::REG_EIFR,   32'h0000_0000, 32'h0000_0020, 1'b0}
    };

    logic                  CLK;
    logic                  RESETn;
    eic_pkg::eic_lines_t   signal;
    eic_pkg::eic_bus_t     bus;
    eic_pkg::eic_addr_t    read_addr;
    eic_pkg::eic_cpu_ack_t ack;
    eic_pkg::eic_word_t    read_data;
    eic_pkg::eic_cpu_req_t req;
    eic_pkg::eic_word_t    last_rand;
    int                    checks;
    int                    errors;
    logic                  step_bad;

    eic_clkgen clk_gen (.CLK(CLK), .RESETn(RESETn));

    eic_top uut (
        .CLK       (CLK),
        .RESETn    (RESETn),
        .signal    (signal),
        .bus       (bus),
        .read_addr (read_addr),
        .ack       (ack),
        .read_data (read_data),
        .req       (req)
    );

    task automatic log_compare(input string name, input logic bad,
                               input eic_pkg::eic_word_t got, input eic_pkg::eic_word_t exp);
        checks++;
        if (bad) begin
            errors++;
            step_bad = 1'b1;
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input eic_pkg::eic_word_t got,
                              input eic_pkg::eic_word_t exp);
        log_compare(name, got !== exp, got, exp);
    endtask

    task automatic check_ipl(input eic_pkg::eic_ipl_t got, input eic_pkg::eic_ipl_t exp);
        log_compare("req.level", got !== exp, eic_pkg::eic_word_t'(got),
                    eic_pkg::eic_word_t'(exp));
    endtask

    task automatic check_vector(input eic_pkg::eic_vector_t got, input eic_pkg::eic_vector_t exp);
        log_compare("req.vector", got !== exp, eic_pkg::eic_word_t'(got),
                    eic_pkg::eic_word_t'(exp));
    endtask

    task automatic check_offset(input eic_pkg::eic_offset_t got, input eic_pkg::eic_offset_t exp);
        log_compare("req.offset", got !== exp, eic_pkg::eic_word_t'(got),
                    eic_pkg::eic_word_t'(exp));
    endtask

    task automatic check_shadow(input eic_pkg::eic_shadow_t got, input eic_pkg::eic_shadow_t exp);
        log_compare("req.shadow_set", got !== exp, eic_pkg::eic_word_t'(got),
                    eic_pkg::eic_word_t'(exp));
    endtask

    task automatic check_present(input logic got, input logic exp);
        log_compare("req.present", got !== exp, eic_pkg::eic_word_t'(got),
                    eic_pkg::eic_word_t'(exp));
    endtask

    task automatic wait_read(input eic_pkg::eic_addr_t addr, input eic_pkg::eic_word_t exp);
        int n;
        n = 0;
        read_addr = addr;
        #1;
        while (read_data !== exp && n < WAIT_LIMIT) begin
            @(negedge CLK);
            #1;
            n++;
        end
        if (read_data !== exp) begin
            $display("timeout: register %0d did not reach its value in %0d cycles", addr, n);
        end
        check_word("read_data", read_data, exp);
    endtask

    // level is number plus 1, offset in halfwords from the vector base
    task automatic wait_level(input eic_pkg::eic_ipl_t lvl);
        int                   n;
        int                   byte_off;
        eic_pkg::eic_vector_t exp_vec;
        eic_pkg::eic_offset_t exp_off;
        n = 0;
        exp_vec = '0;
        exp_off = '0;
        while (req.level !== lvl && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (req.level !== lvl) begin
            $display("timeout: level did not reach %0d in %0d cycles", lvl, n);
        end
        if (lvl != '0) begin
            exp_vec  = eic_pkg::eic_vector_t'(lvl - 8'd1);
            byte_off = eic_pkg::EIC_VECTOR_BASE + int'(exp_vec) * eic_pkg::EIC_VECTOR_SPACING;
            exp_off  = eic_pkg::eic_offset_t'(byte_off / 2);
        end
        check_ipl(req.level, lvl);
        check_vector(req.vector, exp_vec);
        check_offset(req.offset, exp_off);
        check_shadow(req.shadow_set, '0);
    endtask

    task automatic run_step(input step_t s);
        eic_pkg::eic_word_t data;
        eic_pkg::eic_word_t exp;
        data = s.data;
        exp  = s.rnd ? last_rand : s.exp;
        @(negedge CLK);
        case (s.op)
            OP_WRITE: begin
                if (s.rnd) begin
                    last_rand = $urandom;
                    data      = last_rand;
                end
                bus.write_enable = 1'b1;
                bus.write_addr   = s.addr;
                bus.write_data   = data;
                @(negedge CLK);
                bus.write_enable = 1'b0;
            end
            OP_READ: begin
                read_addr = s.addr;
                #1;
                check_word("read_data", read_data, exp);
            end
            OP_WAIT_READ: wait_read(s.addr, exp);
            OP_LINES: signal = data;
            OP_ACK: begin
                ack.iack = 1'b1;
                ack.ivn  = eic_pkg::eic_vector_t'(data);
                @(negedge CLK);
                ack.iack = 1'b0;
            end
            OP_WAIT_LEVEL: wait_level(eic_pkg::eic_ipl_t'(exp));
            default: begin
                #1;
                check_present(req.present, exp[0]);
            end
        endcase
    endtask

    initial begin
        int n;
        signal    = '0;
        bus       = '0;
        read_addr = '0;
        ack       = '0;
        last_rand = '0;
        checks    = 0;
        errors    = 0;
        void'($urandom(32'hd62b));
        n = 0;
        while (RESETn !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (RESETn !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        for (int i = 0; i < NUM_STEPS; i++) begin
            step_bad = 1'b0;
            run_step(STEPS[i]);
            $display("step %0d %s: %s", i, STEPS[i].op.name(), step_bad ? "mismatch" : "ok");
        end
        $display("%0d steps, %0d checks, %0d errors", NUM_STEPS, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
